//--- rv_ex_pkg.sv
package rv_ex_pkg;

    // datapath and register file geometry
    localparam int XLEN           = 64;
    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;  // boot address

    // iterative mul/div sizing
    localparam int MD_STEPS     = 64;                  // one iteration per operand bit
    localparam int MD_CNT_WIDTH = $clog2(MD_STEPS);

    localparam logic [MD_CNT_WIDTH-1:0] MD_LAST = MD_CNT_WIDTH'(MD_STEPS - 1);

    // execute opcodes, alu group first
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_SLL   = 4'd2,
        OP_SRL   = 4'd3,
        OP_SRA   = 4'd4,
        OP_SLT   = 4'd5,
        OP_SLTU  = 4'd6,
        OP_XOR   = 4'd7,
        OP_OR    = 4'd8,
        OP_AND   = 4'd9,
        OP_MUL   = 4'd10,  // low half of product
        OP_MULHU = 4'd11,  // high half, both unsigned
        OP_DIV   = 4'd12,
        OP_DIVU  = 4'd13,
        OP_REM   = 4'd14,
        OP_REMU  = 4'd15
    } alu_op_e;

    // mul/div sequencer
    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_BUSY = 2'd1,
        MD_DONE = 2'd2   // result held until retire
    } md_state_e;

endpackage

//--- id_ex_regs.sv
module id_ex_regs
    import rv_ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      id_valid_i,   // decode has an instruction
    input  logic                      slot_free_i,  // slot empty or retiring now

    input  logic [XLEN-1:0]           id_pc_i,
    input  alu_op_e                   id_op_i,
    input  logic [XLEN-1:0]           id_a_i,
    input  logic [XLEN-1:0]           id_b_i,
    input  logic [REG_ADDR_WIDTH-1:0] id_rd_i,
    input  logic                      id_wen_i,

    output logic                      occ_o,        // slot holds a live instruction
    output logic [XLEN-1:0]           pc_o,
    output alu_op_e                   op_o,
    output logic [XLEN-1:0]           a_o,
    output logic [XLEN-1:0]           b_o,
    output logic [REG_ADDR_WIDTH-1:0] rd_o,
    output logic                      wen_o
);

    logic load;

    assign load = id_valid_i & slot_free_i;

    // occupancy flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_o <= 1'b0;
        end else if (slot_free_i) begin
            occ_o <= id_valid_i;  // refill or drain
        end
    end

    // held instruction fields, frozen while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o  <= RESET_PC;
            op_o  <= OP_ADD;
            a_o   <= '0;
            b_o   <= '0;
            rd_o  <= '0;
            wen_o <= 1'b0;
        end else if (load) begin
            pc_o  <= id_pc_i;
            op_o  <= id_op_i;
            a_o   <= id_a_i;
            b_o   <= id_b_i;
            rd_o  <= id_rd_i;
            wen_o <= id_wen_i;
        end
    end

endmodule

//--- alu_unit.sv
module alu_unit
    import rv_ex_pkg::*;
(
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,

    output logic [XLEN-1:0] result_o
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[5:0];  // rv64 uses six bits
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            OP_ADD: begin
                result_o = a_i + b_i;  // wraps on overflow
            end
            OP_SUB: begin
                result_o = a_i - b_i;
            end
            OP_SLL: begin
                result_o = a_i << shamt;
            end
            OP_SRL: begin
                result_o = a_i >> shamt;
            end
            OP_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            OP_OR: begin
                result_o = a_i | b_i;
            end
            OP_AND: begin
                result_o = a_i & b_i;
            end
            default: begin
                result_o = '0;  // mul/div ops are not ours
            end
        endcase
    end

endmodule

//--- muldiv_unit.sv
module muldiv_unit
    import rv_ex_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            occ_i,     // held slot is live
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  logic            retire_i,  // result accepted downstream

    output logic            claim_o,   // held op belongs to this unit
    output logic            done_o,
    output logic [XLEN-1:0] result_o
);

    md_state_e               md_state;
    logic [MD_CNT_WIDTH-1:0] step_cnt;

    alu_op_e                 md_op;
    logic [2*XLEN-1:0]       acc;      // product or remainder and quotient
    logic [XLEN-1:0]         md_b;     // multiplicand or divisor magnitude
    logic                    neg_q;
    logic                    neg_r;

    logic                    start;
    logic                    op_signed;
    logic                    sign_a;
    logic                    sign_b;
    logic [XLEN-1:0]         a_mag;
    logic [XLEN-1:0]         b_mag;
    logic                    is_mul;

    logic [XLEN:0]           add_sum;
    logic [XLEN:0]           rem_sh;
    logic [XLEN:0]           rem_diff;
    logic                    rem_ge;
    logic [XLEN-1:0]         quo;
    logic [XLEN-1:0]         rem;

    assign claim_o = op_i inside {OP_MUL, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign start   = occ_i & claim_o & (md_state == MD_IDLE);
    assign done_o  = (md_state == MD_DONE);

    assign op_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign sign_a    = op_signed & a_i[XLEN-1];
    assign sign_b    = op_signed & b_i[XLEN-1];
    assign a_mag     = sign_a ? -a_i : a_i;
    assign b_mag     = sign_b ? -b_i : b_i;

    assign is_mul = (md_op == OP_MUL) || (md_op == OP_MULHU);

    // shift-add step where the lsb of acc selects the add
    assign add_sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, md_b} : '0);

    // restoring step on the shifted partial remainder
    assign rem_sh   = acc[2*XLEN-1:XLEN-1];
    assign rem_ge   = rem_sh >= {1'b0, md_b};
    assign rem_diff = rem_sh - {1'b0, md_b};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_state <= MD_IDLE;
            step_cnt <= '0;
        end else begin
            case (md_state)
                MD_IDLE: begin
                    if (start) begin
                        md_state <= MD_BUSY;
                        step_cnt <= '0;
                    end
                end
                MD_BUSY: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == MD_LAST) begin
                        md_state <= MD_DONE;
                    end
                end
                MD_DONE: begin
                    if (retire_i) begin
                        md_state <= MD_IDLE;
                    end
                end
                default: begin
                    md_state <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            md_op <= op_i;
            md_b  <= (op_i inside {OP_MUL, OP_MULHU}) ? a_i : b_mag;
            acc   <= {{XLEN{1'b0}}, (op_i inside {OP_MUL, OP_MULHU}) ? b_i : a_mag};
            neg_q <= (sign_a ^ sign_b) & (|b_i);  // x/0 keeps all ones
            neg_r <= sign_a;                      // remainder follows dividend
        end else if (md_state == MD_BUSY) begin
            if (is_mul) begin
                acc <= {add_sum, acc[XLEN-1:1]};
            end else begin
                acc <= {rem_ge ? rem_diff[XLEN-1:0] : rem_sh[XLEN-1:0],
                        acc[XLEN-2:0], rem_ge};
            end
        end
    end

    assign quo = acc[XLEN-1:0];
    assign rem = acc[2*XLEN-1:XLEN];

    // min over -1 falls out of the magnitude path as min with rem 0
    always_comb begin
        case (md_op)
            OP_MUL:            result_o = acc[XLEN-1:0];
            OP_MULHU:          result_o = acc[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:   result_o = neg_q ? -quo : quo;
            OP_REM, OP_REMU:   result_o = neg_r ? -rem : rem;
            default:           result_o = '0;
        endcase
    end

endmodule

//--- ex_result_sel.sv
module ex_result_sel
    import rv_ex_pkg::*;
(
    input  logic            occ_i,
    input  logic            md_claim_i,    // held op is mul/div
    input  logic            md_done_i,
    input  logic [XLEN-1:0] alu_result_i,
    input  logic [XLEN-1:0] md_result_i,
    input  logic            ex_ready_i,

    output logic            ex_valid_o,
    output logic [XLEN-1:0] ex_result_o,
    output logic            retire_o,
    output logic            slot_free_o    // lets the register take a new op
);

    logic result_ready;

    // alu ops are ready at once, mul/div waits for done
    assign result_ready = ~md_claim_i | md_done_i;

    assign ex_valid_o  = occ_i & result_ready;
    assign ex_result_o = md_claim_i ? md_result_i : alu_result_i;

    assign retire_o    = ex_valid_o & ex_ready_i;
    assign slot_free_o = ~occ_i | retire_o;  // empty, or emptying this edge

endmodule

//--- ex_stage_top.sv
module ex_stage_top
    import rv_ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      id_valid_i,
    input  logic [XLEN-1:0]           id_pc_i,
    input  alu_op_e                   id_op_i,
    input  logic [XLEN-1:0]           id_a_i,
    input  logic [XLEN-1:0]           id_b_i,
    input  logic [REG_ADDR_WIDTH-1:0] id_rd_i,
    input  logic                      id_wen_i,
    output logic                      id_ready_o,

    output logic                      ex_valid_o,
    output logic [XLEN-1:0]           ex_result_o,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd_o,
    output logic                      ex_wen_o,
    output logic [XLEN-1:0]           ex_pc_o,
    input  logic                      ex_ready_i
);

    logic            occ;
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_result;
    logic            md_claim;
    logic            md_done;
    logic [XLEN-1:0] md_result;
    logic            retire;
    logic            slot_free;

    assign id_ready_o = slot_free;  // upstream stall

    id_ex_regs id_ex_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid_i  (id_valid_i),
        .slot_free_i (slot_free),
        .id_pc_i     (id_pc_i),
        .id_op_i     (id_op_i),
        .id_a_i      (id_a_i),
        .id_b_i      (id_b_i),
        .id_rd_i     (id_rd_i),
        .id_wen_i    (id_wen_i),
        .occ_o       (occ),
        .pc_o        (ex_pc_o),
        .op_o        (op),
        .a_o         (a),
        .b_o         (b),
        .rd_o        (ex_rd_o),
        .wen_o       (ex_wen_o)
    );

    alu_unit alu_unit_i (
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .result_o (alu_result)
    );

    muldiv_unit muldiv_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .occ_i    (occ),
        .op_i     (op),
        .a_i      (a),
        .b_i      (b),
        .retire_i (retire),
        .claim_o  (md_claim),
        .done_o   (md_done),
        .result_o (md_result)
    );

    ex_result_sel ex_result_sel_i (
        .occ_i        (occ),
        .md_claim_i   (md_claim),
        .md_done_i    (md_done),
        .alu_result_i (alu_result),
        .md_result_i  (md_result),
        .ex_ready_i   (ex_ready_i),
        .ex_valid_o   (ex_valid_o),
        .ex_result_o  (ex_result_o),
        .retire_o     (retire),
        .slot_free_o  (slot_free)
    );

endmodule

//--- ex_stage_sva.sv
module ex_stage_sva
    import rv_ex_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      id_ready_o,
    input logic                      ex_valid_o,
    input logic [XLEN-1:0]           ex_result_o,
    input logic [REG_ADDR_WIDTH-1:0] ex_rd_o,
    input logic                      ex_wen_o,
    input logic [XLEN-1:0]           ex_pc_o,
    input logic                      ex_ready_i
);

    int err_cnt = 0;  // number of failed assertions

    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !ex_valid_o)
        else begin
            $error("ex_valid_o was high while reset was asserted");
            err_cnt++;
        end

    // downstream stall freezes every ex_ output
    outputs_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_result_o) && $stable(ex_rd_o)
                                      && $stable(ex_wen_o) && $stable(ex_pc_o))
        else begin
            $error("ex_ outputs changed while the consumer stalled the stage");
            err_cnt++;
        end

    upstream_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid_o && !ex_ready_i |-> !id_ready_o)
        else begin
            $error("id_ready_o was high while the held instruction could not retire");
            err_cnt++;
        end

endmodule

bind ex_stage_top ex_stage_sva sva_i (.*);

//--- tb_ex_stage.sv
module tb_ex_stage
    import rv_ex_pkg::*;
();

    localparam int              RST_CYCLES = 5;
    localparam logic [31:0]     LCG_SEED   = 32'h7354e14e;
    localparam logic [XLEN-1:0] PC_BASE    = 64'h0000_0000_0001_0000;
    localparam logic [XLEN-1:0] ALL_ONES   = 64'hffff_ffff_ffff_ffff;
    localparam logic [XLEN-1:0] MOST_NEG   = 64'h8000_0000_0000_0000;

    logic                      clk;
    logic                      rst_n;
    logic                      id_valid_i;
    logic [XLEN-1:0]           id_pc_i;
    alu_op_e                   id_op_i;
    logic [XLEN-1:0]           id_a_i;
    logic [XLEN-1:0]           id_b_i;
    logic [REG_ADDR_WIDTH-1:0] id_rd_i;
    logic                      id_wen_i;
    logic                      id_ready_o;
    logic                      ex_valid_o;
    logic [XLEN-1:0]           ex_result_o;
    logic [REG_ADDR_WIDTH-1:0] ex_rd_o;
    logic                      ex_wen_o;
    logic [XLEN-1:0]           ex_pc_o;
    logic                      ex_ready_i;

    // stimulus table with one slot per instruction
    alu_op_e                   tab_op[$];
    logic [XLEN-1:0]           tab_a[$];
    logic [XLEN-1:0]           tab_b[$];
    logic [REG_ADDR_WIDTH-1:0] tab_rd[$];
    logic                      tab_wen[$];
    int                        tab_stall[$];  // cycles of ex_ready_i low after valid
    int                        n_entries;
    logic [31:0]               rng_state;

    ex_stage_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] rand_word();
        logic [31:0] hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi        = rng_state;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {hi, rng_state};
    endfunction

    // expected result straight from the RV64 rules
    function automatic logic [XLEN-1:0] model_result(alu_op_e op, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      prod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   ovf;
        logic [XLEN-1:0]        res;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        sa   = a;
        sb   = b;
        ovf  = (a == MOST_NEG) && (b == ALL_ONES);
        case (op)
            OP_ADD:   res = a + b;
            OP_SUB:   res = a - b;
            OP_SLL:   res = a << b[5:0];
            OP_SRL:   res = a >> b[5:0];
            OP_SRA:   res = sa >>> b[5:0];
            OP_SLT:   res = {{(XLEN-1){1'b0}}, sa < sb};
            OP_SLTU:  res = {{(XLEN-1){1'b0}}, a < b};
            OP_XOR:   res = a ^ b;
            OP_OR:    res = a | b;
            OP_AND:   res = a & b;
            OP_MUL:   res = prod[XLEN-1:0];
            OP_MULHU: res = prod[2*XLEN-1:XLEN];
            OP_DIV, OP_REM: begin
                if (b == '0) res = (op == OP_DIV) ? ALL_ONES : a;
                else if (ovf) res = (op == OP_DIV) ? a : '0;
                else if (op == OP_DIV) res = sa / sb;
                else res = sa % sb;
            end
            default: begin  // unsigned divide and remainder
                if (b == '0) res = (op == OP_DIVU) ? ALL_ONES : a;
                else if (op == OP_DIVU) res = a / b;
                else res = a % b;
            end
        endcase
        return res;
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_WIDTH-1:0] got,
                            input logic [REG_ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic check_wen(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic add_entry(alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                             logic [REG_ADDR_WIDTH-1:0] rd, logic wen, int stall);
        tab_op.push_back(op);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_rd.push_back(rd);
        tab_wen.push_back(wen);
        tab_stall.push_back(stall);
    endtask

    task automatic fill_table();
        // alu edge operands
        add_entry(OP_ADD,  64'h7fff_ffff_ffff_ffff, 64'd1, 5'd1, 1'b1, 0);  // signed wrap
        add_entry(OP_ADD,  ALL_ONES, 64'd2, 5'd2, 1'b1, 0);
        add_entry(OP_SUB,  64'd0, 64'd1, 5'd3, 1'b1, 0);
        add_entry(OP_SLL,  64'h8000_0000_0000_0001, 64'd0, 5'd4, 1'b0, 0);
        add_entry(OP_SLL,  64'd3, 64'd63, 5'd5, 1'b1, 0);
        add_entry(OP_SRL,  MOST_NEG, 64'd63, 5'd6, 1'b1, 0);
        add_entry(OP_SRA,  MOST_NEG, 64'd63, 5'd7, 1'b1, 0);
        add_entry(OP_SRA,  MOST_NEG, 64'hffff_ffff_ffff_ffc0, 5'd8, 1'b1, 0);  // upper bits ignored
        add_entry(OP_SLT,  ALL_ONES, 64'd1, 5'd9, 1'b1, 0);
        add_entry(OP_SLTU, ALL_ONES, 64'd1, 5'd10, 1'b1, 0);
        add_entry(OP_SLT,  64'd5, 64'd5, 5'd11, 1'b0, 0);
        add_entry(OP_XOR,  ALL_ONES, 64'h5555_5555_5555_5555, 5'd12, 1'b1, 0);
        add_entry(OP_OR,   MOST_NEG, 64'd1, 5'd13, 1'b1, 0);
        add_entry(OP_AND,  ALL_ONES, MOST_NEG, 5'd14, 1'b0, 0);
        // every alu op once more with random operands
        for (int k = 0; k < 10; k++) begin
            add_entry(alu_op_e'(k), rand_word(), rand_word(), 5'(k + 12), k[0], 0);
        end
        // multiplies
        add_entry(OP_MUL,   rand_word(), rand_word(), 5'd22, 1'b1, 0);
        add_entry(OP_MULHU, ALL_ONES, ALL_ONES, 5'd23, 1'b1, 0);
        add_entry(OP_MUL,   MOST_NEG, ALL_ONES, 5'd24, 1'b0, 0);
        add_entry(OP_MULHU, rand_word(), rand_word(), 5'd25, 1'b1, 0);
        add_entry(OP_MUL,   64'd0, rand_word(), 5'd26, 1'b1, 0);
        // divides including the special cases
        add_entry(OP_DIV,  rand_word(), rand_word() >> 40, 5'd27, 1'b1, 0);
        add_entry(OP_DIV,  MOST_NEG, ALL_ONES, 5'd28, 1'b1, 0);  // signed overflow
        add_entry(OP_DIV,  rand_word(), 64'd0, 5'd29, 1'b1, 0);
        add_entry(OP_DIV,  64'hffff_ffff_ffff_fff9, 64'd2, 5'd30, 1'b0, 0);
        add_entry(OP_DIVU, rand_word(), rand_word() >> 33, 5'd31, 1'b1, 0);
        add_entry(OP_DIVU, rand_word(), 64'd0, 5'd1, 1'b1, 0);
        add_entry(OP_REM,  MOST_NEG, ALL_ONES, 5'd2, 1'b1, 0);
        add_entry(OP_REM,  64'hffff_ffff_ffff_fff9, 64'd2, 5'd3, 1'b1, 0);
        add_entry(OP_REM,  rand_word(), 64'd0, 5'd4, 1'b0, 0);
        add_entry(OP_REMU, rand_word(), 64'd0, 5'd5, 1'b1, 0);
        add_entry(OP_REMU, rand_word(), rand_word() >> 20, 5'd6, 1'b1, 0);
        // back-pressure on both kinds of op
        add_entry(OP_ADD,  rand_word(), rand_word(), 5'd7, 1'b1, 4);
        add_entry(OP_DIV,  rand_word(), rand_word() >> 50, 5'd8, 1'b1, 3);
        add_entry(OP_SLL,  rand_word(), 64'd17, 5'd9, 1'b0, 1);
        // mixed back to back
        add_entry(OP_MUL,  rand_word(), rand_word(), 5'd10, 1'b1, 0);
        add_entry(OP_ADD,  rand_word(), rand_word(), 5'd11, 1'b1, 0);
        add_entry(OP_DIVU, rand_word(), rand_word() >> 30, 5'd12, 1'b0, 0);
        add_entry(OP_XOR,  rand_word(), rand_word(), 5'd13, 1'b1, 0);
        add_entry(OP_REM,  rand_word(), rand_word() >> 45, 5'd14, 1'b1, 2);
        add_entry(OP_SUB,  rand_word(), rand_word(), 5'd15, 1'b1, 0);
        n_entries = tab_op.size();
    endtask

    task automatic drive_inputs();
        for (int i = 0; i < n_entries; i++) begin
            id_valid_i <= 1'b1;
            id_pc_i    <= PC_BASE + XLEN'(4 * i);
            id_op_i    <= tab_op[i];
            id_a_i     <= tab_a[i];
            id_b_i     <= tab_b[i];
            id_rd_i    <= tab_rd[i];
            id_wen_i   <= tab_wen[i];
            @(posedge clk);
            while (!id_ready_o) @(posedge clk);  // taken on the edge with ready high
        end
        id_valid_i <= 1'b0;
    endtask

    task automatic check_entry(int j, logic [XLEN-1:0] exp_res, logic [XLEN-1:0] exp_pc);
        check_wen("ex_valid_o", ex_valid_o, 1'b1);
        check_result("ex_result_o", ex_result_o, exp_res);
        check_rd("ex_rd_o", ex_rd_o, tab_rd[j]);
        check_wen("ex_wen_o", ex_wen_o, tab_wen[j]);
        check_result("ex_pc_o", ex_pc_o, exp_pc);
    endtask

    task automatic collect_results();
        logic [XLEN-1:0] exp_res;
        logic [XLEN-1:0] exp_pc;
        ex_ready_i <= (tab_stall[0] == 0);
        for (int j = 0; j < n_entries; j++) begin
            exp_res = model_result(tab_op[j], tab_a[j], tab_b[j]);
            exp_pc  = PC_BASE + XLEN'(4 * j);
            @(posedge clk);
            while (!ex_valid_o) @(posedge clk);
            check_entry(j, exp_res, exp_pc);
            for (int k = 0; k < tab_stall[j]; k++) begin
                check_wen("id_ready_o", id_ready_o, 1'b0);  // held while stalled
                if (k == tab_stall[j] - 1) ex_ready_i <= 1'b1;
                @(posedge clk);
                check_entry(j, exp_res, exp_pc);
            end
            // entry j retired on this edge so set up ready for the next one
            if (j + 1 < n_entries) begin
                ex_ready_i <= (tab_stall[j + 1] == 0);
            end else begin
                ex_ready_i <= 1'b1;
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        id_valid_i = 1'b0;
        id_pc_i    = '0;
        id_op_i    = OP_ADD;
        id_a_i     = '0;
        id_b_i     = '0;
        id_rd_i    = '0;
        id_wen_i   = 1'b0;
        ex_ready_i = 1'b0;
        rng_state  = LCG_SEED;
        fill_table();
        fork
            begin
                repeat (RST_CYCLES + 2 + n_entries * (MD_STEPS + 10)) @(posedge clk);
                $display("timeout: the execute stage stopped producing results");
                $display(">>> FAIL");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_wen("ex_valid_o", ex_valid_o, 1'b0);  // idle out of reset
        check_wen("id_ready_o", id_ready_o, 1'b1);
        fork
            drive_inputs();
            collect_results();
        join
        @(posedge clk);
        if (dut_i.sva_i.err_cnt != 0) begin
            $display("assertion failures were seen during the run");
            $display(">>> FAIL");
            $fatal(1, "handshake assertions failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
rv_ex_pkg.sv
id_ex_regs.sv
alu_unit.sv
muldiv_unit.sv
ex_result_sel.sv
ex_stage_top.sv
ex_stage_sva.sv
tb_ex_stage.sv
